//--- build.f
hw/lidar_pkg.sv
hw/cmd_decoder.sv
hw/tdc_spi_master.sv
hw/tdc_control.sv
hw/sample_fifo.sv
hw/uart_word_tx.sv
hw/lidar_top.sv
sim/tb_lidar_top.sv

//--- hw/cmd_decoder.sv
`timescale 1ns/1ps

module cmd_decoder (
  input  logic             clk,
  input  logic             rst_n,
  input  lidar_pkg::byte_t rx_data,
  input  logic             rx_valid,
  output logic             running,
  output logic             paused
);
  import lidar_pkg::*;

  // every byte is taken, unknown codes fall through
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      paused  <= 1'b0;
    end else if (rx_valid) begin
      case (rx_data)
        CMD_ENABLE: begin
          running <= 1'b1;
          // enable always starts unpaused
          paused  <= 1'b0;
        end
        CMD_DISABLE: begin
          running <= 1'b0;
          paused  <= 1'b0;
        end
        CMD_PAUSE:  paused <= 1'b1;
        CMD_RESUME: paused <= 1'b0;
        default: begin
          // ignored
        end
      endcase
    end
  end

endmodule

//--- hw/lidar_pkg.sv
package lidar_pkg;

  // vector types
  typedef logic [7:0]  byte_t;
  // flight time read back from the converter
  typedef logic [23:0] tdc_time_t;
  typedef logic [7:0]  shot_idx_t;
  // shot index in [31:24], flight time in [23:0]
  typedef logic [31:0] sample_word_t;

  // system clock and shot rate
  localparam int CLK_FREQ_HZ        = 50_000_000;
  localparam int SHOT_FREQ_HZ       = 14_000;
  // rounds down, 3571 clocks
  localparam int SHOT_PERIOD_CYCLES = CLK_FREQ_HZ / SHOT_FREQ_HZ;

  // serial link to host
  localparam int BAUD_RATE    = 4_000_000;
  localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;

  // converter spi, clocks per sck half period
  localparam int TDC_SPI_HZ      = 6_250_000;
  localparam int SPI_HALF_CYCLES = CLK_FREQ_HZ / (2 * TDC_SPI_HZ);

  // 64 sample words
  localparam int FIFO_ADDR_W = 6;

  // start pulse width and interrupt wait
  localparam int TDC_START_CYCLES    = 4;
  localparam int INTB_TIMEOUT_CYCLES = 2000;

  // read flight time register
  localparam byte_t     TDC_READ_CMD = 8'h10;
  // marks a shot without a return
  localparam tdc_time_t TDC_NO_HIT   = '1;

  // host command bytes, ascii E D P R
  localparam byte_t CMD_ENABLE  = 8'h45;
  localparam byte_t CMD_DISABLE = 8'h44;
  localparam byte_t CMD_PAUSE   = 8'h50;
  localparam byte_t CMD_RESUME  = 8'h52;

endpackage

//--- hw/lidar_top.sv
`timescale 1ns/1ps

module lidar_top (
  input  logic             clk,
  input  logic             rst_n,
  input  lidar_pkg::byte_t rx_data,
  input  logic             rx_valid,
  input  logic             tdc_intb,
  input  logic             tdc_dout,
  input  logic             tx_block,
  output logic             tdc_enable,
  output logic             tdc_start,
  output logic             tdc_sck,
  output logic             tdc_mosi,
  output logic             tdc_cs,
  output logic             serial_out
);
  import lidar_pkg::*;

  logic         paused;
  // tdc_control to spi master
  logic         spi_start;
  byte_t        spi_tx;
  logic         spi_last;
  logic         spi_busy;
  logic         spi_done;
  byte_t        spi_rx;
  // measurement side of the fifo
  logic         push_valid;
  logic         push_ready;
  sample_word_t push_data;
  // uart side
  logic         pop_valid;
  logic         pop_ready;
  sample_word_t pop_data;

  // running doubles as the converter enable pin
  cmd_decoder u_cmd_decoder (.running(tdc_enable), .*);

  tdc_control u_tdc_control (.running(tdc_enable), .*);

  tdc_spi_master u_tdc_spi_master (.*);

  sample_fifo u_sample_fifo (.*);

  uart_word_tx u_uart_word_tx (.*);

endmodule

//--- hw/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push_valid,
  output logic                    push_ready,
  input  lidar_pkg::sample_word_t push_data,
  output logic                    pop_valid,
  input  logic                    pop_ready,
  output lidar_pkg::sample_word_t pop_data
);
  import lidar_pkg::*;

  localparam int DEPTH = 2 ** FIFO_ADDR_W;

  sample_word_t           mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] wr_ptr;
  logic [FIFO_ADDR_W-1:0] rd_ptr;
  // one extra bit to tell full from empty
  logic [FIFO_ADDR_W:0]   count;
  logic                   push_fire;
  logic                   pop_fire;

  assign push_ready = (count != (FIFO_ADDR_W + 1)'(DEPTH));
  assign pop_valid  = (count != '0);
  // head word shows without a read cycle
  assign pop_data   = mem[rd_ptr];
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // pointers wrap on their own
      count <= count + push_fire - pop_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- hw/tdc_control.sv
`timescale 1ns/1ps

module tdc_control (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    running,
  input  logic                    paused,
  input  logic                    tdc_intb,
  output logic                    tdc_start,
  output logic                    spi_start,
  output lidar_pkg::byte_t        spi_tx,
  output logic                    spi_last,
  input  logic                    spi_busy,
  input  logic                    spi_done,
  input  lidar_pkg::byte_t        spi_rx,
  output logic                    push_valid,
  input  logic                    push_ready,
  output lidar_pkg::sample_word_t push_data
);
  import lidar_pkg::*;

  localparam int PER_W = $clog2(SHOT_PERIOD_CYCLES + 1);
  localparam int TMR_W = $clog2(INTB_TIMEOUT_CYCLES + 1);

  typedef enum logic [2:0] {st_idle, st_fire, st_wait_intb, st_read, st_push} state_t;

  state_t           state;
  logic [PER_W-1:0] period_cnt;
  // start width, then interrupt wait
  logic [TMR_W-1:0] tmr;
  // spi bytes finished in this read
  logic [1:0]       byte_cnt;
  logic [1:0]       intb_sync;
  shot_idx_t        shot_idx;
  tdc_time_t        time_q;
  logic             shot_fire;
  logic             intb_timeout;

  // period elapsed and nothing in flight
  assign shot_fire = running && !paused && (state == st_idle) &&
                     (period_cnt == PER_W'(SHOT_PERIOD_CYCLES));
  assign intb_timeout = (state == st_wait_intb) && intb_sync[1] &&
                        (tmr == TMR_W'(INTB_TIMEOUT_CYCLES - 1));

  assign tdc_start = (state == st_fire);
  // no start on the done cycle, byte_cnt moves first
  assign spi_start = (state == st_read) && !spi_busy && !spi_done;
  // read command, then dummy bytes to clock out the time
  assign spi_tx    = (byte_cnt == 2'd0) ? TDC_READ_CMD : byte_t'(0);
  assign spi_last  = (byte_cnt == 2'd3);
  // word dropped if disabled while waiting
  assign push_valid = (state == st_push) && running;
  assign push_data  = {shot_idx, time_q};

  // shot period, saturates while a shot is held up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
    end else if (!running) begin
      period_cnt <= '0;
    end else if (shot_fire) begin
      // restart at one so shots are exactly SHOT_PERIOD_CYCLES apart
      period_cnt <= PER_W'(1);
    end else if (!paused && period_cnt != PER_W'(SHOT_PERIOD_CYCLES)) begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      intb_sync <= 2'b11;
      state     <= st_idle;
      tmr       <= '0;
      byte_cnt  <= '0;
      shot_idx  <= '0;
    end else begin
      // interrupt is asynchronous to clk
      intb_sync <= {intb_sync[0], tdc_intb};
      if (!running) begin
        shot_idx <= '0;
      end
      case (state)
        st_idle: begin
          tmr <= '0;
          if (shot_fire) begin
            state <= st_fire;
          end
        end
        st_fire: begin
          if (tmr == TMR_W'(TDC_START_CYCLES - 1)) begin
            tmr   <= '0;
            state <= st_wait_intb;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        st_wait_intb: begin
          byte_cnt <= '0;
          if (!intb_sync[1]) begin
            state <= st_read;
          end else if (intb_timeout) begin
            state <= st_push;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        st_read: begin
          if (spi_done) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
              state <= st_push;
            end
          end
        end
        st_push: begin
          if (!running) begin
            state <= st_idle;
          end else if (push_ready) begin
            // one index per shot, held under back-pressure
            shot_idx <= shot_idx + 1'b1;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // time assembly, msb byte first after the command byte
  always_ff @(posedge clk) begin
    if (intb_timeout) begin
      time_q <= TDC_NO_HIT;
    end else if (state == st_read && spi_done && byte_cnt != 2'd0) begin
      time_q <= {time_q[15:0], spi_rx};
    end
  end

endmodule

//--- hw/tdc_spi_master.sv
`timescale 1ns/1ps

module tdc_spi_master (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             spi_start,
  input  lidar_pkg::byte_t spi_tx,
  input  logic             spi_last,
  output logic             spi_busy,
  output logic             spi_done,
  output lidar_pkg::byte_t spi_rx,
  output logic             tdc_sck,
  output logic             tdc_mosi,
  output logic             tdc_cs,
  input  logic             tdc_dout
);
  import lidar_pkg::*;

  localparam int HALF_W = $clog2(SPI_HALF_CYCLES + 1);

  logic [HALF_W-1:0] half_cnt;
  // 16 sck edges per byte, even ones rise
  logic [3:0]        edge_cnt;
  byte_t             tx_shift;
  byte_t             rx_shift;
  logic              last_q;
  logic              half_end;

  assign half_end = spi_busy && (half_cnt == HALF_W'(SPI_HALF_CYCLES - 1));
  // msb first, mode 0
  assign tdc_mosi = tx_shift[7];
  // complete once the last rising edge has passed
  assign spi_rx   = rx_shift;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_busy <= 1'b0;
      spi_done <= 1'b0;
      tdc_sck  <= 1'b0;
      tdc_cs   <= 1'b1;
      half_cnt <= '0;
      edge_cnt <= '0;
      last_q   <= 1'b0;
      tx_shift <= '0;
    end else begin
      spi_done <= 1'b0;
      if (spi_start && !spi_busy) begin
        // cs falls with the first byte, stays low between bytes
        spi_busy <= 1'b1;
        tdc_cs   <= 1'b0;
        half_cnt <= '0;
        edge_cnt <= '0;
        last_q   <= spi_last;
        tx_shift <= spi_tx;
      end else if (half_end) begin
        half_cnt <= '0;
        tdc_sck  <= ~tdc_sck;
        edge_cnt <= edge_cnt + 4'd1;
        // next data bit goes out on the falling edge
        if (tdc_sck && edge_cnt != 4'd15) begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
        if (edge_cnt == 4'd15) begin
          spi_busy <= 1'b0;
          spi_done <= 1'b1;
          if (last_q) begin
            tdc_cs <= 1'b1;
          end
        end
      end else if (spi_busy) begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // sample miso as sck rises
  always_ff @(posedge clk) begin
    if (half_end && !tdc_sck) begin
      rx_shift <= {rx_shift[6:0], tdc_dout};
    end
  end

endmodule

//--- hw/uart_word_tx.sv
`timescale 1ns/1ps

module uart_word_tx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    pop_valid,
  output logic                    pop_ready,
  input  lidar_pkg::sample_word_t pop_data,
  input  logic                    tx_block,
  output logic                    serial_out
);
  import lidar_pkg::*;

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  typedef enum logic [1:0] {st_idle, st_gap, st_send, st_done} state_t;

  state_t           state;
  sample_word_t     word_q;
  // stop, 8 data, start; ones shift in behind
  logic [9:0]       shift_q;
  logic [CNT_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic [1:0]       byte_cnt;

  // all ones between frames, so the line idles high
  assign serial_out = shift_q[0];
  // word leaves the fifo once its last stop bit is out
  assign pop_ready  = (state == st_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      shift_q  <= '1;
      clk_cnt  <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          byte_cnt <= '0;
          if (pop_valid) begin
            state <= st_gap;
          end
        end
        // host block only looked at between bytes
        st_gap: begin
          if (!tx_block) begin
            shift_q <= {1'b1, word_q[31:24], 1'b0};
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= st_send;
          end
        end
        st_send: begin
          if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shift_q <= {1'b1, shift_q[9:1]};
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd9) begin
              byte_cnt <= byte_cnt + 2'd1;
              state    <= (byte_cnt == 2'd3) ? st_done : st_gap;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        st_done: state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // msb byte sits on top, shifted up as each byte is loaded
  always_ff @(posedge clk) begin
    if (state == st_idle && pop_valid) begin
      word_q <= pop_data;
    end else if (state == st_gap && !tx_block) begin
      word_q <= {word_q[23:0], 8'h00};
    end
  end

endmodule

//--- sim/tb_lidar_top.sv
`timescale 1ns/1ps

module tb_lidar_top;
  import lidar_pkg::*;

  localparam int PERIOD   = SHOT_PERIOD_CYCLES;
  localparam int WATCHDOG = 200 * SHOT_PERIOD_CYCLES;
  // converter answers this long after the start pulse rises
  localparam int INTB_DELAY = 20;

  logic  clk;
  logic  rst_n;
  byte_t rx_data;
  logic  rx_valid;
  logic  tdc_intb;
  logic  tdc_dout;
  logic  tx_block;
  logic  tdc_enable;
  logic  tdc_start;
  logic  tdc_sck;
  logic  tdc_mosi;
  logic  tdc_cs;
  logic  serial_out;

  int           errors;
  int           checks;
  int           start_count;
  int           rx_words;
  logic         skip_next;
  shot_idx_t    exp_idx;
  // expected words in shot order
  sample_word_t exp_q[$];
  logic [15:0]  lfsr;

  lidar_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one lfsr step per bit taken
  function automatic tdc_time_t random_time();
    tdc_time_t v;
    v = '0;
    for (int i = 0; i < 24; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[22:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic send_cmd(input byte_t code);
    @(posedge clk);
    #1;
    rx_data  = code;
    rx_valid = 1'b1;
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
  endtask

  task automatic wait_words(input int target, input int max_cycles);
    int n;
    n = 0;
    while (rx_words < target && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (rx_words < target) begin
      errors++;
      $display("timed out with %0d of %0d serial words received", rx_words, target);
    end
  endtask

  task automatic wait_start(input int max_cycles);
    int n;
    int s0;
    n  = 0;
    s0 = start_count;
    while (start_count == s0 && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (start_count == s0) begin
      errors++;
      $display("timed out waiting for a start pulse");
    end
  endtask

  // start only while enabled and never during a read
  assert property (@(posedge clk) disable iff (!rst_n) tdc_start |-> tdc_enable)
    else begin
      errors++;
      $display("start pulse while the converter is disabled");
    end
  assert property (@(posedge clk) disable iff (!rst_n) !tdc_cs |-> !tdc_start)
    else begin
      errors++;
      $display("start pulse while chip select is low");
    end

  // converter model acting 1 ns after each rising clock edge
  initial begin : tdc_model
    logic        start_q;
    logic        cs_q;
    logic        sck_q;
    int          intb_wait;
    int          skip_watch;
    int          sck_rises;
    byte_t       cmd_q;
    logic [31:0] serve_q;
    tdc_time_t   t;
    start_q    = 1'b0;
    cs_q       = 1'b1;
    sck_q      = 1'b0;
    intb_wait  = 0;
    skip_watch = 0;
    sck_rises  = 0;
    cmd_q      = '0;
    serve_q    = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n) begin
        if (tdc_start && !start_q) begin
          start_count++;
          if (skip_next) begin
            // withhold the interrupt so the dut times out
            skip_next  = 1'b0;
            skip_watch = INTB_TIMEOUT_CYCLES + 40;
            exp_q.push_back({exp_idx, TDC_NO_HIT});
          end else begin
            t = random_time();
            serve_q   = {8'h00, t};
            intb_wait = INTB_DELAY;
            exp_q.push_back({exp_idx, t});
          end
          exp_idx++;
        end
        if (intb_wait > 0) begin
          intb_wait--;
          if (intb_wait == 0) begin
            tdc_intb = 1'b0;
          end
        end
        if (skip_watch > 0) begin
          skip_watch--;
          check_value("tdc_cs during skipped shot", tdc_cs, 1'b1);
        end
        // first bit must be ready before the first rising sck
        if (!tdc_cs && cs_q) begin
          sck_rises = 0;
          tdc_dout  = serve_q[31];
        end
        if (!tdc_cs && tdc_sck && !sck_q) begin
          if (sck_rises < 8) begin
            cmd_q = {cmd_q[6:0], tdc_mosi};
          end
          sck_rises++;
          if (sck_rises == 8) begin
            check_value("tdc_mosi command byte", cmd_q, TDC_READ_CMD);
          end
        end
        // next bit goes out after each falling sck
        if (!tdc_cs && !tdc_sck && sck_q && sck_rises < 32) begin
          tdc_dout = serve_q[31 - sck_rises];
        end
        if (tdc_cs && !cs_q) begin
          tdc_intb = 1'b1;
          check_value("tdc_sck rising edges per cs window", sck_rises, 32);
        end
      end
      start_q = tdc_start;
      cs_q    = tdc_cs;
      sck_q   = tdc_sck;
    end
  end

  // serial decoder sampling at bit centres
  initial begin : uart_decoder
    byte_t        b;
    logic [31:0]  word;
    int           nbytes;
    sample_word_t exp;
    b      = '0;
    word   = '0;
    nbytes = 0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && serial_out === 1'b0) begin
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        #1;
        check_value("serial_out start bit", serial_out, 1'b0);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(posedge clk);
          #1;
          // lsb first
          b = {serial_out, b[7:1]};
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
        check_value("serial_out stop bit", serial_out, 1'b1);
        word = {word[23:0], b};
        nbytes++;
        if (nbytes == 4) begin
          nbytes = 0;
          if (exp_q.size() == 0) begin
            errors++;
            $display("serial word 0x%h arrived with no shot fired for it", word);
          end else begin
            exp = exp_q.pop_front();
            check_value("serial word shot index", word[31:24], exp[31:24]);
            check_value("serial word flight time", word[23:0], exp[23:0]);
          end
          rx_words++;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired before the test sequence ended");
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : test_seq
    int   s0;
    int   n0;
    logic line_all;
    errors      = 0;
    checks      = 0;
    start_count = 0;
    rx_words    = 0;
    skip_next   = 1'b0;
    exp_idx     = '0;
    lfsr        = 16'd88;
    rst_n       = 1'b0;
    rx_data     = '0;
    rx_valid    = 1'b0;
    tdc_intb    = 1'b1;
    tdc_dout    = 1'b0;
    tx_block    = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state and two idle periods
    check_value("tdc_enable", tdc_enable, 1'b0);
    check_value("tdc_start", tdc_start, 1'b0);
    check_value("tdc_cs", tdc_cs, 1'b1);
    check_value("tdc_sck", tdc_sck, 1'b0);
    check_value("serial_out", serial_out, 1'b1);
    repeat (2 * PERIOD) @(posedge clk);
    #1;
    check_value("start pulses before enable", start_count, 0);

    // normal measurement
    send_cmd(CMD_ENABLE);
    check_value("tdc_enable", tdc_enable, 1'b1);
    wait_words(3, 5 * PERIOD);

    // withheld interrupt gives a no-hit word
    skip_next = 1'b1;
    wait_words(rx_words + 2, 4 * PERIOD);

    // pause just after a start lets that shot finish
    n0 = rx_words;
    wait_start(2 * PERIOD);
    s0 = start_count;
    send_cmd(CMD_PAUSE);
    repeat (2 * PERIOD) @(posedge clk);
    #1;
    // the shot in flight is already counted in s0
    check_value("start pulses while paused", start_count - s0, 0);
    wait_words(n0 + 1, PERIOD);
    send_cmd(CMD_RESUME);
    wait_words(n0 + 4, 5 * PERIOD);

    // host block long enough to fill the fifo
    n0 = rx_words;
    s0 = start_count;
    tx_block = 1'b1;
    repeat (10 * CLKS_PER_BIT + 2) @(posedge clk);
    line_all = 1'b1;
    repeat (68 * PERIOD) begin
      @(posedge clk);
      #1;
      line_all = line_all & serial_out;
    end
    check_value("serial_out", line_all, 1'b1);
    // 64 in the fifo plus one held in tdc_control
    check_value("start pulses while blocked", start_count - s0, 2 ** FIFO_ADDR_W + 1);
    tx_block = 1'b0;
    wait_words(n0 + 2 ** FIFO_ADDR_W + 3, 20 * PERIOD);

    // disable and re-enable restart the index at zero
    send_cmd(CMD_DISABLE);
    check_value("tdc_enable", tdc_enable, 1'b0);
    s0 = start_count;
    repeat (2 * PERIOD) @(posedge clk);
    #1;
    check_value("start pulses after disable", start_count - s0, 0);
    exp_idx = '0;
    send_cmd(CMD_ENABLE);
    wait_words(rx_words + 2, 4 * PERIOD);
    check_value("words still expected", exp_q.size(), 0);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
